/* flist.f */
common/mipsPkg.sv
hdl/dataMem.sv
hdl/timer/timer.sv
hdl/bridge/northBridge.sv
hdl/bridge/southBridge.sv
hdl/mips.sv
dv/mipsTb.sv

/* run.sh */
#!/bin/sh
# Build and run the MIPS microsystem testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f flist.f --top-module mipsTb \
    --Mdir obj_dir -o mipsTbSim

./obj_dir/mipsTbSim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Run failed, see $LOG"
    exit 1
fi

echo "Run finished, see $LOG"
exit 0

/* dv/mipsTb.sv */
////////////////////////////////////////////////////////////
// MIPS microsystem testbench
// Acts as the CPU on the north bridge port and checks the
// memory map, the response timing and the interrupts
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mipsTb;
    import mipsPkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset;
    logic        interrupt;
    busReq_t     req;
    logic        reqValid;
    logic        reqReady;
    logic        rspValid;
    logic [31:0] rspData;
    logic [7:2]  hwInt;

    // Shadow of data memory and predictions waiting for a response
    logic [31:0] shadow [DM_WORDS];
    logic [32:0] expQ [$];
    logic [31:0] addrList [16];
    logic [31:0] lastRsp;
    logic [31:0] rngState = 32'hca77_b1c7;
    int          rspCount = 0;
    int          errors = 0;
    int          checks = 0;

    mips uut (
        .clk(clk), .reset(reset), .interrupt(interrupt), .req(req),
        .reqValid(reqValid), .reqReady(reqReady), .rspValid(rspValid),
        .rspData(rspData), .hwInt(hwInt)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Bit 32 marks a predictable value since timer registers are live
    function automatic logic [32:0] predictResponse(input busReq_t r);
        logic [31:0] word;
        if (r.addr <= DM_LIMIT) begin
            word = shadow[r.addr[11:2]];
            if (!r.write) begin
                return {1'b1, word};
            end
            for (int i = 0; i < 4; i++) begin
                if (r.be[i]) begin
                    word[8*i +: 8] = r.wData[8*i +: 8];
                end
            end
            shadow[r.addr[11:2]] = word;
            return {1'b1, 32'd0};
        end
        if (!r.write && r.addr >= TIMER0_BASE && r.addr <= TIMER1_BASE + 32'd15
                && r.addr[3:2] != 2'd3) begin
            return {1'b0, 32'd0};
        end
        return {1'b1, 32'd0};
    endfunction

    task automatic flagError(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            flagError($sformatf("%s: got %h, expected %h", what, got, want));
        end
    endtask

    task automatic stopOnTimeout(input string what);
        $display("Timeout while waiting for %s at %0t ns", what, $time);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic endTest(input int num, input string name, input int errStart);
        $display("Test %0d %s: %0d errors", num, name, errors - errStart);
    endtask

    // One CPU request that returns once its response has been taken
    task automatic busTransfer(input logic [31:0] addr, input logic [31:0] wData,
                               input logic [3:0] be, input logic write,
                               output logic [31:0] rData);
        busReq_t r;
        int      waitCnt;
        int      target;
        r.addr = addr;
        r.wData = wData;
        r.be = be;
        r.write = write;
        @(negedge clk);
        req = r;
        reqValid = 1'b1;
        waitCnt = 0;
        while (reqReady !== 1'b1) begin
            if (waitCnt == WAIT_LIMIT) stopOnTimeout("reqReady");
            @(negedge clk);
            waitCnt++;
        end
        target = rspCount + 1;
        @(posedge clk);
        expQ.push_back(predictResponse(r));
        @(negedge clk);
        reqValid = 1'b0;
        waitCnt = 0;
        @(posedge clk);
        while (rspCount < target) begin
            if (waitCnt == WAIT_LIMIT) stopOnTimeout("rspValid");
            @(posedge clk);
            waitCnt++;
        end
        rData = lastRsp;
    endtask

    // Each response must come one cycle after its accept
    always @(negedge clk) begin : compareResponses
        logic [32:0] expEntry;
        if (!reset && rspValid) begin
            if (reqReady !== 1'b0) flagError("reqReady high in the response cycle");
            if (expQ.size() == 0) begin
                flagError("response without an accepted request");
            end else begin
                expEntry = expQ.pop_front();
                lastRsp = rspData;
                rspCount++;
                checks++;
                if (expEntry[32] && rspData !== expEntry[31:0]) begin
                    flagError($sformatf("rspData %h, expected %h", rspData, expEntry[31:0]));
                end
            end
        end else if (!reset && expQ.size() != 0) begin
            flagError("no response in the cycle after the accept");
            expQ.delete();
        end
    end

    initial begin
        int          errStart;
        int          elapsed;
        int          presetN;
        logic [31:0] a;
        logic [31:0] rnd;
        logic [31:0] rdata;
        logic [7:2]  expVec;
        clk = 1'b0;
        reset = 1'b1;
        interrupt = 1'b0;
        req = '0;
        reqValid = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        errStart = errors;
        compareWord("reqReady after reset", {31'd0, reqReady}, 32'd1);
        compareWord("rspValid after reset", {31'd0, rspValid}, 32'd0);
        compareWord("hwInt after reset", {26'd0, hwInt}, 32'd0);
        endTest(1, "reset state", errStart);

        errStart = errors;
        for (int i = 0; i < 16; i++) begin
            rnd = nextRandom();
            addrList[i] = rnd & 32'h0000_0FFC;
            busTransfer(addrList[i], nextRandom(), 4'hF, 1'b1, rdata);
        end
        for (int i = 0; i < 16; i++) begin
            busTransfer(addrList[i], 32'd0, 4'hF, 1'b0, rdata);
        end
        endTest(2, "full-word writes and reads", errStart);

        errStart = errors;
        for (int i = 0; i < 16; i++) begin
            a = nextRandom() & 32'h0000_0FFC;
            busTransfer(a, nextRandom(), 4'hF, 1'b1, rdata);
            rnd = nextRandom();
            busTransfer(a, nextRandom(), rnd[3:0], 1'b1, rdata);
            busTransfer(a, 32'd0, 4'hF, 1'b0, rdata);
        end
        endTest(3, "byte-enable writes", errStart);

        // Unmapped aliases of a data memory word and timer index 3
        errStart = errors;
        a = nextRandom() & 32'h0000_0FFC;
        busTransfer(a, nextRandom(), 4'hF, 1'b1, rdata);
        busTransfer(32'h0000_1000 | a, nextRandom(), 4'hF, 1'b1, rdata);
        busTransfer(32'h0001_0000 | a, nextRandom(), 4'hF, 1'b1, rdata);
        busTransfer(a, 32'd0, 4'hF, 1'b0, rdata);
        busTransfer(32'h0000_1000 | a, 32'd0, 4'hF, 1'b0, rdata);
        busTransfer(32'h0000_7F20, 32'd0, 4'hF, 1'b0, rdata);
        busTransfer(TIMER0_BASE + 32'd12, 32'd0, 4'hF, 1'b0, rdata);
        busTransfer(TIMER1_BASE + 32'd12, 32'd0, 4'hF, 1'b0, rdata);
        busTransfer(TIMER0_BASE + 32'd4, 32'h0000_0055, 4'hF, 1'b1, rdata);
        busTransfer(TIMER0_BASE + 32'd12, 32'hFFFF_FFFF, 4'hF, 1'b1, rdata);
        busTransfer(32'h0000_7F20, 32'hFFFF_FFFF, 4'hF, 1'b1, rdata);
        busTransfer(TIMER0_BASE + 32'd4, 32'd0, 4'hF, 1'b0, rdata);
        compareWord("timer 0 PRESET", rdata, 32'h0000_0055);
        busTransfer(TIMER0_BASE + 32'd8, 32'd0, 4'hF, 1'b0, rdata);
        compareWord("timer 0 COUNT", rdata, 32'h0000_0055);
        busTransfer(TIMER0_BASE, 32'd0, 4'hF, 1'b0, rdata);
        compareWord("timer 0 CTRL", rdata, 32'd0);
        endTest(4, "unmapped accesses", errStart);

        // Timer 0 one-shot with mask set and then timer 1 auto-reload
        errStart = errors;
        rnd = nextRandom();
        presetN = 4 + int'(rnd[3:0]);
        busTransfer(TIMER0_BASE + 32'd4, presetN, 4'hF, 1'b1, rdata);
        busTransfer(TIMER0_BASE, 32'h0000_0009, 4'hF, 1'b1, rdata);
        elapsed = 1;
        @(negedge clk);
        while (hwInt[HWINT_TIMER0] !== 1'b1) begin
            if (elapsed == WAIT_LIMIT) stopOnTimeout("the timer 0 interrupt");
            @(negedge clk);
            elapsed++;
        end
        checks++;
        if (elapsed > presetN + 2) begin
            flagError($sformatf("timer 0 irq after %0d cycles, preset %0d", elapsed, presetN));
        end
        busTransfer(TIMER0_BASE, 32'd0, 4'hF, 1'b0, rdata);
        compareWord("timer 0 CTRL after one-shot", rdata, 32'h0000_0008);
        busTransfer(TIMER0_BASE, 32'h0000_0008, 4'hF, 1'b1, rdata);
        @(negedge clk);
        compareWord("timer 0 irq after CTRL write", {31'd0, hwInt[HWINT_TIMER0]}, 32'd0);
        presetN = 3 + int'(rnd[6:4]);
        busTransfer(TIMER1_BASE + 32'd4, presetN, 4'hF, 1'b1, rdata);
        busTransfer(TIMER1_BASE, 32'h0000_000B, 4'hF, 1'b1, rdata);
        for (int k = 0; k < 3; k++) begin
            elapsed = 0;
            @(negedge clk);
            while (hwInt[HWINT_TIMER1] !== 1'b1) begin
                if (elapsed == WAIT_LIMIT) stopOnTimeout("the timer 1 interrupt");
                @(negedge clk);
                elapsed++;
            end
            busTransfer(TIMER1_BASE + 32'd8, 32'd0, 4'hF, 1'b0, rdata);
            checks++;
            if (rdata > 32'(presetN)) flagError($sformatf("timer 1 COUNT %0d", rdata));
            // Auto-reload keeps the enable set
            busTransfer(TIMER1_BASE, 32'd0, 4'hF, 1'b0, rdata);
            compareWord("timer 1 CTRL while reloading", rdata, 32'h0000_000B);
            busTransfer(TIMER1_BASE, 32'h0000_000B, 4'hF, 1'b1, rdata);
        end
        busTransfer(TIMER1_BASE, 32'h0000_0008, 4'hF, 1'b1, rdata);
        @(negedge clk);
        compareWord("timer 1 irq after stop", {31'd0, hwInt[HWINT_TIMER1]}, 32'd0);
        endTest(5, "timer interrupts", errStart);

        // Timer 0 runs to pending with its mask clear
        errStart = errors;
        busTransfer(TIMER0_BASE + 32'd4, 32'd3, 4'hF, 1'b1, rdata);
        busTransfer(TIMER0_BASE, 32'h0000_0001, 4'hF, 1'b1, rdata);
        busTransfer(TIMER1_BASE, 32'd0, 4'hF, 1'b1, rdata);
        expVec = '0;
        expVec[HWINT_EXT] = 1'b1;
        @(negedge clk);
        interrupt = 1'b1;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            compareWord("hwInt with external interrupt", {26'd0, hwInt}, {26'd0, expVec});
        end
        interrupt = 1'b0;
        @(negedge clk);
        compareWord("hwInt after external interrupt", {26'd0, hwInt}, 32'd0);
        endTest(6, "external interrupt", errStart);

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/mips.sv */
////////////////////////////////////////////////////////////
// MIPS microsystem top level
// North bridge, data memory, south bridge and two timers
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mips (
    input  logic             clk,
    input  logic             reset,
    input  logic             interrupt,
    input  mipsPkg::busReq_t req,
    input  logic             reqValid,
    output logic             reqReady,
    output logic             rspValid,
    output logic [31:0]      rspData,
    output logic [7:2]       hwInt
);
    import mipsPkg::*;

    // Data memory port
    busReq_t     dmReq;
    logic        dmSel;
    logic [31:0] dmRData;

    // South bridge port
    busReq_t     sbReq;
    logic        sbSel;
    logic [31:0] sbRData;

    // Timers
    periphReq_t  timer0Req;
    periphReq_t  timer1Req;
    logic        timer0Sel;
    logic        timer1Sel;
    logic [31:0] timer0RData;
    logic [31:0] timer1RData;
    logic        timer0Irq;
    logic        timer1Irq;

    northBridge nbridge (
        .clk(clk), .reset(reset),
        .req(req), .reqValid(reqValid), .reqReady(reqReady),
        .rspValid(rspValid), .rspData(rspData),
        .dmReq(dmReq), .dmSel(dmSel), .dmRData(dmRData),
        .sbReq(sbReq), .sbSel(sbSel), .sbRData(sbRData)
    );

    dataMem dm (
        .clk(clk), .req(dmReq), .sel(dmSel), .rData(dmRData)
    );

    southBridge sbridge (
        .clk(clk),
        .req(sbReq), .sel(sbSel), .rData(sbRData),
        .timer0Req(timer0Req), .timer1Req(timer1Req),
        .timer0Sel(timer0Sel), .timer1Sel(timer1Sel),
        .timer0RData(timer0RData), .timer1RData(timer1RData),
        .timer0Irq(timer0Irq), .timer1Irq(timer1Irq),
        .extInt(interrupt), .hwInt(hwInt)
    );

    timer timer0 (
        .clk(clk), .reset(reset),
        .req(timer0Req), .sel(timer0Sel), .rData(timer0RData), .irq(timer0Irq)
    );

    timer timer1 (
        .clk(clk), .reset(reset),
        .req(timer1Req), .sel(timer1Sel), .rData(timer1RData), .irq(timer1Irq)
    );

endmodule

`default_nettype wire

/* hdl/bridge/southBridge.sv */
////////////////////////////////////////////////////////////
// South bridge
// Splits the peripheral window between the two timers,
// muxes their read data and builds the interrupt vector
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module southBridge (
    input  logic                 clk,
    input  mipsPkg::busReq_t     req,
    input  logic                 sel,
    output logic [31:0]          rData,
    output mipsPkg::periphReq_t  timer0Req,
    output mipsPkg::periphReq_t  timer1Req,
    output logic                 timer0Sel,
    output logic                 timer1Sel,
    input  logic [31:0]          timer0RData,
    input  logic [31:0]          timer1RData,
    input  logic                 timer0Irq,
    input  logic                 timer1Irq,
    input  logic                 extInt,
    output logic [7:2]           hwInt
);
    import mipsPkg::*;

    logic upperTimer;

    // Address bit 4 picks timer 1
    assign upperTimer = req.addr[4];
    assign timer0Sel = sel && !upperTimer;
    assign timer1Sel = sel && upperTimer;

    // Full word writes only, byte enables are not forwarded
    always_comb begin
        timer0Req.regIdx = req.addr[3:2];
        timer0Req.wData = req.wData;
        timer0Req.wEn = req.write && timer0Sel;

        timer1Req.regIdx = req.addr[3:2];
        timer1Req.wData = req.wData;
        timer1Req.wEn = req.write && timer1Sel;
    end

    always_comb begin
        rData = '0;
        if (timer0Sel) begin
            rData = timer0RData;
        end else if (timer1Sel) begin
            rData = timer1RData;
        end
    end

    // Fixed vector positions, upper bits unused
    always_comb begin
        hwInt = '0;
        hwInt[HWINT_TIMER0] = timer0Irq;
        hwInt[HWINT_TIMER1] = timer1Irq;
        hwInt[HWINT_EXT] = extInt;
    end

endmodule

`default_nettype wire

/* hdl/bridge/northBridge.sv */
////////////////////////////////////////////////////////////
// North bridge
// Decodes CPU requests to data memory or south bridge and
// returns one response the cycle after each accept
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module northBridge (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::busReq_t req,
    input  logic             reqValid,
    output logic             reqReady,
    output logic             rspValid,
    output logic [31:0]      rspData,
    output mipsPkg::busReq_t dmReq,
    output logic             dmSel,
    input  logic [31:0]      dmRData,
    output mipsPkg::busReq_t sbReq,
    output logic             sbSel,
    input  logic [31:0]      sbRData
);
    import mipsPkg::*;

    typedef enum logic [1:0] {
        srcNone,
        srcDm,
        srcSb
    } rspSrc_e;

    logic        accept;
    logic        dmHit;
    logic        sbHit;
    rspSrc_e     rspSrc;
    logic [31:0] sbRDataQ;

    // Address decode
    assign dmHit = (req.addr & ~(DM_LIMIT - DM_BASE)) == DM_BASE;
    assign sbHit = (req.addr >= TIMER0_BASE) && (req.addr <= PERIPH_LIMIT);

    // Only one request in flight, so stall during the response cycle
    assign reqReady = !rspValid;
    assign accept = reqValid && reqReady;

    assign dmSel = accept && dmHit;
    assign sbSel = accept && sbHit;
    assign dmReq = req;
    assign sbReq = req;

    always_ff @(posedge clk) begin
        if (reset) begin
            rspValid <= 1'b0;
            rspSrc <= srcNone;
        end else begin
            rspValid <= accept;
            if (accept) begin
                // Writes and unmapped reads answer with zero
                if (req.write) begin
                    rspSrc <= srcNone;
                end else if (dmHit) begin
                    rspSrc <= srcDm;
                end else if (sbHit) begin
                    rspSrc <= srcSb;
                end else begin
                    rspSrc <= srcNone;
                end
            end
        end
    end

    // Timer data is combinational, hold it for the response
    always_ff @(posedge clk) begin
        if (sbSel) begin
            sbRDataQ <= sbRData;
        end
    end

    always_comb begin
        rspData = '0;
        if (rspValid) begin
            case (rspSrc)
                srcDm:   rspData = dmRData;
                srcSb:   rspData = sbRDataQ;
                default: rspData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/timer/timer.sv */
////////////////////////////////////////////////////////////
// Programmable timer
// Down counter with one-shot and auto-reload modes and a
// masked interrupt
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module timer (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::periphReq_t req,
    input  logic                sel,
    output logic [31:0]         rData,
    output logic                irq
);
    import mipsPkg::*;

    logic        enable;
    timerMode_e  mode;
    logic        mask;
    logic [31:0] preset;
    logic [31:0] count;
    logic        pending;
    logic        wrCtrl;
    logic        wrPreset;
    timerMode_e  wrMode;

    assign wrCtrl = sel && req.wEn && (req.regIdx == regCtrl);
    assign wrPreset = sel && req.wEn && (req.regIdx == regPreset);

    // Unused mode codes fall back to one-shot
    assign wrMode = (req.wData[CTRL_MODE_HI:CTRL_MODE_LO] == modeAutoReload) ?
                    modeAutoReload : modeOneShot;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            mode <= modeOneShot;
            mask <= 1'b0;
            preset <= '0;
            count <= '0;
            pending <= 1'b0;
        end else begin
            if (enable) begin
                if (count > 32'd1) begin
                    count <= count - 32'd1;
                end else if (count == 32'd1) begin
                    // Terminal count
                    count <= '0;
                    pending <= 1'b1;
                    if (mode == modeOneShot) begin
                        enable <= 1'b0;
                    end
                end else if (mode == modeAutoReload) begin
                    count <= preset;
                end else begin
                    enable <= 1'b0;
                end
            end

            // Register writes take priority over counting
            if (wrCtrl) begin
                enable <= req.wData[CTRL_EN];
                mode <= wrMode;
                mask <= req.wData[CTRL_MASK];
                pending <= 1'b0;
            end
            if (wrPreset) begin
                preset <= req.wData;
                count <= req.wData;
            end
        end
    end

    always_comb begin
        rData = '0;
        case (req.regIdx)
            regCtrl:   rData = {28'd0, mask, mode, enable};
            regPreset: rData = preset;
            regCount:  rData = count;
            default:   rData = '0;
        endcase
    end

    assign irq = pending && mask;

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
////////////////////////////////////////////////////////////
// Data memory
// Word-addressed synchronous RAM with byte-enable writes
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dataMem (
    input  logic             clk,
    input  mipsPkg::busReq_t req,
    input  logic             sel,
    output logic [31:0]      rData
);
    import mipsPkg::*;

    logic [31:0] mem [DM_WORDS];
    logic [9:0]  wordIdx;

    // Byte address to word index
    assign wordIdx = req.addr[11:2];

    always_ff @(posedge clk) begin
        if (sel && req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    mem[wordIdx][8*i +: 8] <= req.wData[8*i +: 8];
                end
            end
        end
    end

    // Read data lands in the response cycle
    always_ff @(posedge clk) begin
        if (sel && !req.write) begin
            rData <= mem[wordIdx];
        end
    end

endmodule

`default_nettype wire

/* common/mipsPkg.sv */
////////////////////////////////////////////////////////////
// MIPS microsystem shared definitions
// Memory map, bus structs, interrupt positions, timer types
////////////////////////////////////////////////////////////
`default_nettype none

package mipsPkg;

    // Data memory window, 4 KB from address zero
    localparam int unsigned DM_WORDS = 1024;
    localparam logic [31:0] DM_BASE = 32'h0000_0000;
    localparam logic [31:0] DM_LIMIT = 32'h0000_0FFF;

    // Peripheral window, 16 bytes per timer
    localparam logic [31:0] TIMER0_BASE = 32'h0000_7F00;
    localparam logic [31:0] TIMER1_BASE = 32'h0000_7F10;
    localparam logic [31:0] PERIPH_LIMIT = TIMER1_BASE + 32'h0000_000F;

    // Positions in the hwInt[7:2] vector
    localparam int HWINT_TIMER0 = 2;
    localparam int HWINT_TIMER1 = 3;
    localparam int HWINT_EXT = 4;

    // Timer CTRL register fields
    localparam int CTRL_EN = 0;
    localparam int CTRL_MODE_LO = 1;
    localparam int CTRL_MODE_HI = 2;
    localparam int CTRL_MASK = 3;

    // CPU side request
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wData;
        logic [3:0]  be;
        logic        write;
    } busReq_t;

    // Timer register access
    typedef struct packed {
        logic [1:0]  regIdx;
        logic [31:0] wData;
        logic        wEn;
    } periphReq_t;

    typedef enum logic [1:0] {
        regCtrl   = 2'd0,
        regPreset = 2'd1,
        regCount  = 2'd2
    } timerReg_e;

    typedef enum logic [1:0] {
        modeOneShot    = 2'd0,
        modeAutoReload = 2'd1
    } timerMode_e;

endpackage

`default_nettype wire
